//--- soc_lite.f
source/soc_pkg.sv
source/bus_if.sv
source/bus_xbar.sv
source/ram_1p.sv
source/gpio.sv
source/timer_regs.sv
source/timer_core.sv
source/intr_ctrl.sv
source/soc_lite_top.sv
test/tb_soc_lite.sv

//--- test/soc_lite_vectors.txt
# op a b c, all hex, unused fields 0. W addr data be | R addr rdata err | P pins
# N cycles | Q irq id | O gpio_o gpio_en_o | X random word count
Q 0    0        0
O 0    0        0
# ram full words, then partial byte enables
W 0000 11223344 f
W 0004 a5a5a5a5 f
R 0000 11223344 0
R 0004 a5a5a5a5 0
W 0000 0000ee00 2
W 0004 99000000 8
R 0000 1122ee44 0
R 0004 99a5a5a5 0
W 0008 ffffffff f
W 0008 00000000 5
R 0008 ff00ff00 0
X 10   0        0
# unmapped regions and undefined offsets
R 4000 00000000 1
W 5000 12345678 f
R f004 00000000 1
R 1014 00000000 0
R 2010 00000000 0
R 300c 00000000 0
# gpio outputs, inputs and edge interrupts
W 1004 000000a5 f
W 1008 0000000f f
R 1004 000000a5 0
R 1008 0000000f 0
O a5   0f       0
P 3c   0        0
N 4    0        0
R 1000 0000003c 0
R 1010 0000003c 0
W 1010 0000003c f
R 1010 00000000 0
P 34   0        0
N 4    0        0
P 3c   0        0
N 4    0        0
R 1010 00000008 0
W 100c 00000008 f
# timer
R 2000 00000000 0
W 2004 00001234 f
R 2004 00001234 0
W 2008 00000010 f
W 2004 00000000 f
W 2000 00000001 f
N 18   0        0
W 200c 00000001 f
R 200c 00000001 0
# interrupt controller
Q 0    0        0
W 3000 000001ff f
R 3004 00000108 0
R 3008 00000004 0
Q 1    4        0
W 3000 000001f7 f
R 3008 00000009 0
Q 1    9        0
W 1010 000000ff f
W 200c 00000000 f
Q 0    0        0
R 3004 00000000 0
R 3008 00000000 0

//--- test/tb_soc_lite.sv
// ************************************************
// vectors come from test/soc_lite_vectors.txt, run from project root
// random RAM traffic stays in words 128..255
// ************************************************
`timescale 1ns/10ps

module tb_soc_lite import soc_pkg::*; ();

  logic              clk;
  logic              rst;
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [BE_W-1:0]   be;
  logic              gnt;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic              err;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_en;
  logic              irq;
  logic [ID_W-1:0]   irq_id;

  // parsed vector lines
  byte               op_q [$];
  logic [31:0]       a_q [$];
  logic [31:0]       b_q [$];
  logic [31:0]       c_q [$];

  logic [DATA_W-1:0] ram_model [RAM_DEPTH];
  integer            seed = 32'hf9d4;
  int                n_checks = 0;
  int                n_errors = 0;
  int                cycles = 0;
  int                cycle_limit = 2000;

  // response owed by the request granted on the last edge
  bit                pend_valid = 1'b0;
  logic [DATA_W-1:0] pend_data;
  logic              pend_err;
  logic [ADDR_W-1:0] pend_addr;

  soc_lite_top u_soc_lite_top (
    .clk_i     (clk),
    .rst_i     (rst),
    .req_i     (req),
    .we_i      (we),
    .addr_i    (addr),
    .wdata_i   (wdata),
    .be_i      (be),
    .gnt_o     (gnt),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .err_o     (err),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_en_o (gpio_en),
    .irq_o     (irq),
    .irq_id_o  (irq_id)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic set_idle();
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    be    = '0;
  endtask

  task automatic model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                             input logic [BE_W-1:0] b);
    for (int k = 0; k < BE_W; k++) begin
      if (b[k]) begin
        ram_model[a[RAM_AW+1:2]][k*8 +: 8] = d[k*8 +: 8];
      end
    end
  endtask

  // called on a falling edge, one cycle after the grant
  task automatic collect_response();
    if (pend_valid) begin
      check($sformatf("rvalid @%04h", pend_addr), 32'(rvalid), 32'h1);
      check($sformatf("rdata @%04h", pend_addr), rdata, pend_data);
      check($sformatf("err @%04h", pend_addr), 32'(err), 32'(pend_err));
      pend_valid = 1'b0;
    end else begin
      check("rvalid while idle", 32'(rvalid), 32'h0);
    end
  endtask

  // presents a request, possibly in the cycle the previous response returns
  task automatic issue(input logic w, input logic [ADDR_W-1:0] a,
                       input logic [DATA_W-1:0] d, input logic [BE_W-1:0] b,
                       input logic [DATA_W-1:0] exp_d, input logic exp_e);
    int waited;
    waited = 0;
    @(negedge clk);
    collect_response();
    req   = 1'b1;
    we    = w;
    addr  = a;
    wdata = d;
    be    = b;
    @(posedge clk);
    while (gnt !== 1'b1 && waited < 8) begin
      waited++;
      @(posedge clk);
    end
    if (gnt !== 1'b1) begin
      n_errors++;
      $display("request to address %04h was never granted", a);
    end else begin
      pend_valid = 1'b1;
      pend_data  = exp_d;
      pend_err   = exp_e;
      pend_addr  = a;
    end
  endtask

  task automatic flush();
    @(negedge clk);
    collect_response();
    set_idle();
  endtask

  // writes answer with zero data, err only outside the four regions
  task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                           input logic [BE_W-1:0] b);
    if (a[15:12] == RGN_RAM) begin
      model_write(a, d, b);
    end
    issue(1'b1, a, d, b, '0, a[15:12] > RGN_INTR);
  endtask

  // back-to-back full writes, partial writes, then reads
  task automatic random_ram(input int n);
    logic [ADDR_W-1:0] addrs [$];
    logic [31:0]       r;
    logic [DATA_W-1:0] d;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      d = $random(seed);
      addrs.push_back({6'b0, 1'b1, r[6:0], 2'b00});
      bus_write(addrs[i], d, 4'hf);
    end
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      d = $random(seed);
      bus_write(addrs[i], d, r[3:0]);
    end
    for (int i = 0; i < n; i++) begin
      issue(1'b0, addrs[i], '0, '0, ram_model[addrs[i][RAM_AW+1:2]], 1'b0);
    end
    flush();
  endtask

  task automatic load_vectors(output bit ok);
    int          fd;
    int          code;
    string       tok;
    string       rest;
    logic [31:0] fa;
    logic [31:0] fb;
    logic [31:0] fc;
    ok = 1'b0;
    fd = $fopen("test/soc_lite_vectors.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.getc(0) == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h", fa, fb, fc);
          if (code != 3) begin
            $display("vector line for operation %s has missing fields", tok);
            ok = 1'b0;
          end else begin
            op_q.push_back(tok.getc(0));
            a_q.push_back(fa);
            b_q.push_back(fb);
            c_q.push_back(fc);
          end
        end
      end
      $fclose(fd);
    end
    if (op_q.size() == 0) begin
      ok = 1'b0;
    end
  endtask

  task automatic run_vectors();
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "W": begin
          bus_write(a_q[i][ADDR_W-1:0], b_q[i], c_q[i][BE_W-1:0]);
          flush();
        end
        "R": begin
          issue(1'b0, a_q[i][ADDR_W-1:0], '0, '0, b_q[i], c_q[i][0]);
          flush();
        end
        "P": begin
          @(negedge clk);
          gpio_in = a_q[i][GPIO_W-1:0];
        end
        "N": begin
          repeat (a_q[i]) @(negedge clk);
        end
        "Q": begin
          @(negedge clk);
          check("irq_o", 32'(irq), 32'(a_q[i][0]));
          check("irq_id_o", 32'(irq_id), 32'(b_q[i][ID_W-1:0]));
        end
        "O": begin
          @(negedge clk);
          check("gpio_o", 32'(gpio_out), 32'(a_q[i][GPIO_W-1:0]));
          check("gpio_en_o", 32'(gpio_en), 32'(b_q[i][GPIO_W-1:0]));
        end
        "X": begin
          random_ram(a_q[i]);
        end
        default: begin
          n_errors++;
          $display("vector %0d has an unknown operation code", i);
        end
      endcase
    end
  endtask

  initial begin
    bit ok;
    set_idle();
    gpio_in = '0;
    rst     = 1'b1;
    load_vectors(ok);
    if (!ok) begin
      $display("the vector file could not be opened or read");
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      // each vector line gets a fixed allowance on top of the base
      cycle_limit = 40 * op_q.size() + 2000;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check("gnt_o after reset", 32'(gnt), 32'h0);
      check("rvalid_o after reset", 32'(rvalid), 32'h0);
      check("err_o after reset", 32'(err), 32'h0);
      check("irq_o after reset", 32'(irq), 32'h0);
      run_vectors();
      @(negedge clk);
      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

//--- source/soc_lite_top.sv
// ************************************************
// soc_lite: host bus, RAM, GPIO, timer, intr controller
// single synchronous reset rst_i for all blocks
// ************************************************
`timescale 1ns/10ps

module soc_lite_top import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  // host bus
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [BE_W-1:0]   be_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,
  // pins
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_en_o,
  // interrupt out
  output logic              irq_o,
  output logic [ID_W-1:0]   irq_id_o
);

  bus_if host_bus ();
  bus_if ram_bus ();
  bus_if gpio_bus ();
  bus_if tmr_bus ();
  bus_if ic_bus ();

  logic [GPIO_W-1:0]  intr_gpio;
  logic               intr_timer;
  logic [NUM_SRC-1:0] intr_vector;
  logic               tmr_run;
  logic               tmr_load;
  logic [DATA_W-1:0]  tmr_load_val;
  logic [DATA_W-1:0]  tmr_compare;
  logic [DATA_W-1:0]  tmr_count;
  logic               tmr_expired;

  assign host_bus.req   = req_i;
  assign host_bus.we    = we_i;
  assign host_bus.addr  = addr_i;
  assign host_bus.wdata = wdata_i;
  assign host_bus.be    = be_i;
  assign gnt_o          = host_bus.gnt;
  assign rvalid_o       = host_bus.rvalid;
  assign rdata_o        = host_bus.rdata;
  assign err_o          = host_bus.err;

  bus_xbar u_xbar (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .host  (host_bus),
    .ram   (ram_bus),
    .gpio  (gpio_bus),
    .tmr   (tmr_bus),
    .ic    (ic_bus)
  );

  ram_1p u_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (ram_bus)
  );

  gpio u_gpio (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .bus       (gpio_bus),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (intr_gpio)
  );

  timer_regs u_timer_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .bus        (tmr_bus),
    .count_i    (tmr_count),
    .expired_i  (tmr_expired),
    .run_o      (tmr_run),
    .load_o     (tmr_load),
    .load_val_o (tmr_load_val),
    .compare_o  (tmr_compare),
    .intr_o     (intr_timer)
  );

  timer_core u_timer_core (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .run_i      (tmr_run),
    .load_i     (tmr_load),
    .load_val_i (tmr_load_val),
    .compare_i  (tmr_compare),
    .count_o    (tmr_count),
    .expired_o  (tmr_expired)
  );

  // timer on top at SRC_TIMER, gpio bits below
  assign intr_vector = {intr_timer, intr_gpio};

  intr_ctrl u_intr_ctrl (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .bus      (ic_bus),
    .src_i    (intr_vector),
    .irq_o    (irq_o),
    .irq_id_o (irq_id_o)
  );

endmodule

//--- source/intr_ctrl.sv
// ************************************************
// level sources, no priority, no claim/complete
// id is lowest pending index plus one, 0 when idle
// ************************************************
`timescale 1ns/10ps

module intr_ctrl import soc_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_i,
  bus_if.device              bus,
  input  logic [NUM_SRC-1:0] src_i,
  output logic               irq_o,
  output logic [ID_W-1:0]    irq_id_o
);

  logic [NUM_SRC-1:0] enable_q;
  logic [NUM_SRC-1:0] pending;
  logic [ID_W-1:0]    id;
  logic [DATA_W-1:0]  rd_val;
  logic               rvalid_q;
  logic [DATA_W-1:0]  rdata_q;

  assign bus.gnt = bus.req;
  assign pending = src_i & enable_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      enable_q <= '0;
    end else if (bus.req && bus.we && bus.addr == IC_ENABLE) begin
      enable_q <= bus.wdata[NUM_SRC-1:0];
    end
  end

  // scan from the top so the lowest index is left standing
  always_comb begin
    id = '0;
    for (int i = NUM_SRC - 1; i >= 0; i--) begin
      if (pending[i]) begin
        id = ID_W'(i + 1);
      end
    end
  end

  always_comb begin
    case (bus.addr)
      IC_ENABLE:  rd_val = DATA_W'(enable_q);
      IC_PENDING: rd_val = DATA_W'(pending);
      IC_ID:      rd_val = DATA_W'(id);
      default:    rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : rd_val;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign irq_id_o = id;
  assign irq_o    = (id != '0);

  // reported id names an enabled source that is really up
  a_irq_id_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_o |-> (irq_id_o != '0) && pending[irq_id_o - 1'b1]);

endmodule

//--- source/timer_core.sv
// ************************************************
// 32-bit up counter, wraps silently
// expired is a level while count >= compare (unsigned)
// ************************************************
`timescale 1ns/10ps

module timer_core import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              run_i,
  input  logic              load_i,
  input  logic [DATA_W-1:0] load_val_i,
  input  logic [DATA_W-1:0] compare_i,
  output logic [DATA_W-1:0] count_o,
  output logic              expired_o
);

  logic [DATA_W-1:0] count_q;

  // load wins over counting
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= load_val_i;
    end else if (run_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o   = count_q;
  assign expired_o = (count_q >= compare_i);

endmodule

//--- source/timer_regs.sv
// ************************************************
// register side of the timer, counter lives in timer_core
// COUNT write is a load strobe in the grant cycle
// ************************************************
`timescale 1ns/10ps

module timer_regs import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  bus_if.device             bus,
  input  logic [DATA_W-1:0] count_i,
  input  logic              expired_i,
  output logic              run_o,
  output logic              load_o,
  output logic [DATA_W-1:0] load_val_o,
  output logic [DATA_W-1:0] compare_o,
  output logic              intr_o
);

  logic              run_q;
  logic [DATA_W-1:0] compare_q;
  logic              intr_en_q;
  logic              wr;
  logic [DATA_W-1:0] rd_val;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  assign bus.gnt = bus.req;
  assign wr      = bus.req & bus.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_q     <= 1'b0;
      compare_q <= '0;
      intr_en_q <= 1'b0;
    end else if (wr) begin
      case (bus.addr)
        TMR_CTRL:    run_q     <= bus.wdata[0];
        TMR_COMPARE: compare_q <= bus.wdata;
        TMR_INTR_EN: intr_en_q <= bus.wdata[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (bus.addr)
      TMR_CTRL:    rd_val = DATA_W'(run_q);
      TMR_COUNT:   rd_val = count_i;
      TMR_COMPARE: rd_val = compare_q;
      TMR_INTR_EN: rd_val = DATA_W'(intr_en_q);
      default:     rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : rd_val;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  // core picks the value up on this same edge
  assign load_o     = wr & (bus.addr == TMR_COUNT);
  assign load_val_o = bus.wdata;
  assign run_o      = run_q;
  assign compare_o  = compare_q;
  assign intr_o     = intr_en_q & expired_i;

endmodule

//--- source/gpio.sv
// ************************************************
// 8 pins, two-flop input sync, rising-edge interrupts
// register writes are full word, be is ignored
// ************************************************
`timescale 1ns/10ps

module gpio import soc_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  bus_if.device             bus,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_en_o,
  output logic [GPIO_W-1:0] intr_o
);

  logic [GPIO_W-1:0] data_out_q;
  logic [GPIO_W-1:0] dir_q;
  logic [GPIO_W-1:0] intr_en_q;
  logic [GPIO_W-1:0] intr_state_q;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] prev_q;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] clr;
  logic              wr;
  logic [DATA_W-1:0] rd_val;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  assign bus.gnt = bus.req;
  assign wr      = bus.req & bus.we;
  assign rise    = sync2_q & ~prev_q;
  assign clr     = (wr && bus.addr == GPIO_INTR_STATE) ? bus.wdata[GPIO_W-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q      <= '0;
      sync2_q      <= '0;
      prev_q       <= '0;
      data_out_q   <= '0;
      dir_q        <= '0;
      intr_en_q    <= '0;
      intr_state_q <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // a fresh edge beats a clear in the same cycle
      intr_state_q <= (intr_state_q & ~clr) | rise;
      if (wr) begin
        case (bus.addr)
          GPIO_DATA_OUT: data_out_q <= bus.wdata[GPIO_W-1:0];
          GPIO_DIR:      dir_q      <= bus.wdata[GPIO_W-1:0];
          GPIO_INTR_EN:  intr_en_q  <= bus.wdata[GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (bus.addr)
      GPIO_DATA_IN:    rd_val = DATA_W'(sync2_q);
      GPIO_DATA_OUT:   rd_val = DATA_W'(data_out_q);
      GPIO_DIR:        rd_val = DATA_W'(dir_q);
      GPIO_INTR_EN:    rd_val = DATA_W'(intr_en_q);
      GPIO_INTR_STATE: rd_val = DATA_W'(intr_state_q);
      default:         rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : rd_val;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign gpio_o    = data_out_q;
  assign gpio_en_o = dir_q;
  assign intr_o    = intr_state_q & intr_en_q;

endmodule

//--- source/ram_1p.sv
// ************************************************
// single-port word RAM, contents not reset
// word index from addr[9:2], byte writes through be
// ************************************************
`timescale 1ns/10ps

module ram_1p import soc_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  bus_if.device bus
);

  logic [DATA_W-1:0] mem [RAM_DEPTH];
  logic [RAM_AW-1:0] idx;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  assign idx     = bus.addr[RAM_AW+1:2];
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (bus.be[b]) begin
          mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      rdata_q <= bus.we ? '0 : mem[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  a_addr_known: assert property (@(posedge clk_i) disable iff (rst_i)
    bus.req |-> !$isunknown(bus.addr));

endmodule

//--- source/bus_xbar.sv
// ************************************************
// one host, four devices, decode on addr[15:12]
// devices see the offset only; unmapped regions get err
// ************************************************
`timescale 1ns/10ps

module bus_xbar import soc_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  bus_if.device host,
  bus_if.host   ram,
  bus_if.host   gpio,
  bus_if.host   tmr,
  bus_if.host   ic
);

  logic [RGN_W-1:0]  rgn;
  logic [ADDR_W-1:0] ofs;
  logic              miss;
  logic [3:0]        hit;
  logic [3:0]        dev_gnt;
  logic [3:0]        dev_rvalid;
  // bit 4 marks an unmapped access
  logic [4:0]        sel_q;

  assign rgn  = host.addr[ADDR_W-1:OFS_W];
  assign ofs  = {{RGN_W{1'b0}}, host.addr[OFS_W-1:0]};
  assign hit  = {rgn == RGN_INTR, rgn == RGN_TIMER, rgn == RGN_GPIO, rgn == RGN_RAM};
  assign miss = ~|hit;

  assign ram.req   = host.req & hit[0];
  assign ram.we    = host.we;
  assign ram.addr  = ofs;
  assign ram.wdata = host.wdata;
  assign ram.be    = host.be;

  assign gpio.req   = host.req & hit[1];
  assign gpio.we    = host.we;
  assign gpio.addr  = ofs;
  assign gpio.wdata = host.wdata;
  assign gpio.be    = host.be;

  assign tmr.req   = host.req & hit[2];
  assign tmr.we    = host.we;
  assign tmr.addr  = ofs;
  assign tmr.wdata = host.wdata;
  assign tmr.be    = host.be;

  assign ic.req   = host.req & hit[3];
  assign ic.we    = host.we;
  assign ic.addr  = ofs;
  assign ic.wdata = host.wdata;
  assign ic.be    = host.be;

  assign dev_gnt    = {ic.gnt, tmr.gnt, gpio.gnt, ram.gnt};
  assign dev_rvalid = {ic.rvalid, tmr.rvalid, gpio.rvalid, ram.rvalid};

  // misses are accepted here
  assign host.gnt = |(hit & dev_gnt) | (host.req & miss);

  // remember who owes the response on the next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q <= '0;
    end else if (host.req && host.gnt) begin
      sel_q <= {miss, hit};
    end else begin
      sel_q <= '0;
    end
  end

  assign host.rvalid = sel_q[4] | |(sel_q[3:0] & dev_rvalid);
  assign host.err    = sel_q[4];
  assign host.rdata  = ({DATA_W{sel_q[0] & ram.rvalid}}  & ram.rdata)  |
                       ({DATA_W{sel_q[1] & gpio.rvalid}} & gpio.rdata) |
                       ({DATA_W{sel_q[2] & tmr.rvalid}}  & tmr.rdata)  |
                       ({DATA_W{sel_q[3] & ic.rvalid}}   & ic.rdata);

  // a device answers only for a request granted one cycle earlier
  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    (dev_rvalid & ~sel_q[3:0]) == '0);

  // and a granted device never skips its answer
  a_rvalid_follows_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    |sel_q[3:0] |-> |(sel_q[3:0] & dev_rvalid));

endmodule

//--- source/bus_if.sv
// ************************************************
// req/gnt request bus with a one-cycle rvalid response
// host holds the request until gnt is seen
// ************************************************
`timescale 1ns/10ps

interface bus_if import soc_pkg::*; ();

  // request side
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [BE_W-1:0]   be;

  // response side
  logic              gnt;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic              err;

  modport host (
    output req, we, addr, wdata, be,
    input  gnt, rvalid, rdata, err
  );

  modport device (
    input  req, we, addr, wdata, be,
    output gnt, rvalid, rdata, err
  );

endinterface

//--- source/soc_pkg.sv
// ************************************************
// widths, address map and register offsets of soc_lite
// offsets are byte addresses within a 4 KiB region
// ************************************************
package soc_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // region code sits in the top address bits, the rest is the offset
  localparam int RGN_W = 4;
  localparam int OFS_W = ADDR_W - RGN_W;

  localparam logic [RGN_W-1:0] RGN_RAM   = 4'd0;
  localparam logic [RGN_W-1:0] RGN_GPIO  = 4'd1;
  localparam logic [RGN_W-1:0] RGN_TIMER = 4'd2;
  localparam logic [RGN_W-1:0] RGN_INTR  = 4'd3;

  localparam int RAM_DEPTH = 256;
  localparam int RAM_AW    = $clog2(RAM_DEPTH);

  localparam int GPIO_W = 8;

  localparam logic [ADDR_W-1:0] GPIO_DATA_IN    = 16'h0000;
  localparam logic [ADDR_W-1:0] GPIO_DATA_OUT   = 16'h0004;
  localparam logic [ADDR_W-1:0] GPIO_DIR        = 16'h0008;
  localparam logic [ADDR_W-1:0] GPIO_INTR_EN    = 16'h000c;
  localparam logic [ADDR_W-1:0] GPIO_INTR_STATE = 16'h0010;

  localparam logic [ADDR_W-1:0] TMR_CTRL    = 16'h0000;
  localparam logic [ADDR_W-1:0] TMR_COUNT   = 16'h0004;
  localparam logic [ADDR_W-1:0] TMR_COMPARE = 16'h0008;
  localparam logic [ADDR_W-1:0] TMR_INTR_EN = 16'h000c;

  localparam logic [ADDR_W-1:0] IC_ENABLE  = 16'h0000;
  localparam logic [ADDR_W-1:0] IC_PENDING = 16'h0004;
  localparam logic [ADDR_W-1:0] IC_ID      = 16'h0008;

  // gpio bits take sources 0..7, the timer is last
  localparam int NUM_SRC   = 9;
  localparam int SRC_TIMER = 8;
  localparam int ID_W      = 4;

endpackage
